// File: Makefile
TOOL       := verilator
TOP        := fetch_tb
FILELIST   := compile.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Testbench passed
FAIL_MSG   := Testbench failed

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides, the exit code of the binary is not trusted
sim: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation incomplete"; exit 1; fi
	@echo "simulation ok"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
hw/fetch_pkg.sv
hw/inst_mem.sv
hw/inst_realigner.sv
hw/branch_target_buffer.sv
hw/fetch_stage.sv
hw/fetch_top.sv
tests/tb_clock_gen.sv
tests/fetch_tb.sv

// File: hw/branch_target_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module branch_target_buffer import fetch_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst_n,
    // lookup for the current fetch pc
    input  wire logic [xlen-1:0] lookup_pc_i,
    output logic                 hit_o,
    output logic                 taken_o,
    output logic      [xlen-1:0] target_o,
    // training from execute
    input  wire logic            update_valid_i,
    input  wire btb_update_t     update_i
);

    // one table slot
    typedef struct packed {
        logic [btb_tag_w-1:0] tag;
        logic                 taken;
        logic [xlen-1:0]      target;
    } btb_entry_t;

    logic [btb_entries-1:0] valid_q;
    btb_entry_t             entry_q [btb_entries];

    logic [btb_idx_w-1:0]   lookup_idx;
    logic [btb_tag_w-1:0]   lookup_tag;
    logic [btb_idx_w-1:0]   update_idx;
    btb_entry_t             rd_entry;
    btb_entry_t             wr_entry;

    // halfword aligned pcs, bit 0 is never part of index or tag
    assign lookup_idx = lookup_pc_i[btb_idx_w:1];
    assign lookup_tag = lookup_pc_i[xlen-1:btb_idx_w+1];
    assign update_idx = update_i.pc[btb_idx_w:1];

    // combinational read
    assign rd_entry = entry_q[lookup_idx];
    assign hit_o = valid_q[lookup_idx] && (rd_entry.tag == lookup_tag);
    assign taken_o = rd_entry.taken;
    assign target_o = rd_entry.target;

    assign wr_entry.tag = update_i.pc[xlen-1:btb_idx_w+1];
    assign wr_entry.taken = update_i.taken;
    assign wr_entry.target = update_i.target;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (update_valid_i) begin
            valid_q[update_idx] <= 1'b1;
        end
    end

    // direct mapped, an update simply replaces the slot
    always_ff @(posedge clk) begin
        if (update_valid_i) begin
            entry_q[update_idx] <= wr_entry;
        end
    end

endmodule

`default_nettype wire

// File: hw/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // datapath and address width
    localparam int unsigned xlen = 32;
    // word address width, pc without its byte offset
    localparam int unsigned word_aw = xlen - 2;

    // packets decode can hold, also the reset credit count
    localparam int unsigned fetch_credits = 4;
    localparam int unsigned credit_w = $clog2(fetch_credits + 1);

    // btb geometry, index from pc[4:1], tag from pc[31:5]
    localparam int unsigned btb_entries = 16;
    localparam int unsigned btb_idx_w = $clog2(btb_entries);
    localparam int unsigned btb_tag_w = xlen - btb_idx_w - 1;

    // instruction ram depth in words
    localparam int unsigned imem_words = 256;
    localparam int unsigned imem_aw = $clog2(imem_words);

    // rv32 major opcodes
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_jal = 7'b1101111;
    localparam logic [6:0] opcode_jalr = 7'b1100111;

    // rvc quadrants holding the control transfers
    localparam logic [1:0] rvc_quad1 = 2'b01;
    localparam logic [1:0] rvc_quad2 = 2'b10;

    // addi x0, x0, 0
    localparam logic [31:0] nop_inst = 32'h0000_0013;

    // full width view
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv32_fields_t;

    // compressed view, upper half is padding
    typedef struct packed {
        logic [15:0] pad;
        logic [2:0]  funct3;
        logic        bit12;
        logic [4:0]  rd_rs1;
        logic [4:0]  rs2;
        logic [1:0]  quadrant;
    } rvc_fields_t;

    typedef union packed {
        rv32_fields_t rv32;
        rvc_fields_t  rvc;
    } inst_word_u;

    // one instruction toward decode
    typedef struct packed {
        logic [xlen-1:0] pc;
        inst_word_u      inst;
        logic            compressed;
        logic [xlen-1:0] pred_dest;
    } fetch_pkt_t;

    // btb training from execute
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic            taken;
        logic [xlen-1:0] target;
    } btb_update_t;

endpackage

`default_nettype wire

// File: hw/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_stage import fetch_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst_n,
    // decode returns one credit per packet consumed
    input  wire logic               credit_return_i,
    // redirect from execute
    input  wire logic               make_correction_i,
    input  wire logic [xlen-1:0]    correction_pc_i,
    input  wire logic               btb_update_valid_i,
    input  wire btb_update_t        btb_update_i,
    // memory
    input  wire logic [xlen-1:0]    imem_rdata_i,
    output logic                    imem_ren_o,
    output logic      [imem_aw-1:0] imem_addr_o,
    // packet to decode
    output logic                    pkt_valid_o,
    output fetch_pkt_t              pkt_o
);

    logic [xlen-1:0]     pc_q;
    logic [xlen-1:0]     pc_d;
    logic [credit_w-1:0] credit_q;

    inst_word_u          inst;
    logic                inst_ready;
    logic                compressed;
    logic                btb_hit, btb_taken;
    logic [xlen-1:0]     btb_target;

    logic                rv_branch, rv_jump;
    logic                c_branch, c_jump, c_jr_jalr;
    logic                is_branch, is_jump;
    logic [xlen-1:0]     pc_step;
    logic [xlen-1:0]     next_pc;
    logic                send;

    inst_realigner u_realigner (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc_i         (pc_q),
        .imem_rdata_i (imem_rdata_i),
        .imem_ren_o   (imem_ren_o),
        .imem_addr_o  (imem_addr_o),
        .inst_ready_o (inst_ready),
        .compressed_o (compressed),
        .inst_o       (inst)
    );

    branch_target_buffer u_btb (
        .clk            (clk),
        .rst_n          (rst_n),
        .lookup_pc_i    (pc_q),
        .hit_o          (btb_hit),
        .taken_o        (btb_taken),
        .target_o       (btb_target),
        .update_valid_i (btb_update_valid_i),
        .update_i       (btb_update_i)
    );

    // rv32 control transfers
    assign rv_branch = (inst.rv32.opcode == opcode_branch);
    assign rv_jump = (inst.rv32.opcode == opcode_jal) || (inst.rv32.opcode == opcode_jalr);
    // c.beqz, c.bnez
    assign c_branch = (inst.rvc.quadrant == rvc_quad1) && (inst.rvc.funct3[2:1] == 2'b11);
    // c.jr, c.jalr; rs1 of zero is c.ebreak
    assign c_jr_jalr = (inst.rvc.quadrant == rvc_quad2) && (inst.rvc.funct3 == 3'b100)
                       && (inst.rvc.rs2 == 5'd0) && (inst.rvc.rd_rs1 != 5'd0);
    // c.j, c.jal
    assign c_jump = c_jr_jalr || ((inst.rvc.quadrant == rvc_quad1)
                    && ((inst.rvc.funct3 == 3'b101) || (inst.rvc.funct3 == 3'b001)));

    assign is_branch = compressed ? c_branch : rv_branch;
    assign is_jump = compressed ? c_jump : rv_jump;

    // jumps always follow a btb hit, branches only when marked taken
    assign pc_step = pc_q + (compressed ? xlen'(2) : xlen'(4));
    assign next_pc = (btb_hit && (is_jump || (is_branch && btb_taken))) ? btb_target : pc_step;

    // correction kills the packet of this cycle
    assign send = inst_ready && (credit_q != '0) && !make_correction_i;

    always_comb begin
        if (make_correction_i) begin
            pc_d = correction_pc_i;
        end else if (send) begin
            pc_d = next_pc;
        end else begin
            // no instruction or no credit
            pc_d = pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= '0;
            credit_q <= credit_w'(fetch_credits);
            pkt_valid_o <= 1'b0;
        end else begin
            pc_q <= pc_d;
            // send and return can land in the same cycle
            credit_q <= credit_q - credit_w'(send) + credit_w'(credit_return_i);
            pkt_valid_o <= send;
        end
    end

    // packet payload
    always_ff @(posedge clk) begin
        if (send) begin
            pkt_o.pc <= pc_q;
            pkt_o.inst <= inst;
            pkt_o.compressed <= compressed;
            pkt_o.pred_dest <= next_pc;
        end
    end

endmodule

`default_nettype wire

// File: hw/fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst_n,
    // program load, used while in reset
    input  wire logic               load_we_i,
    input  wire logic [imem_aw-1:0] load_addr_i,
    input  wire logic [xlen-1:0]    load_data_i,
    // decode side
    input  wire logic               credit_return_i,
    output logic                    pkt_valid_o,
    output fetch_pkt_t              pkt_o,
    // execute side
    input  wire logic               make_correction_i,
    input  wire logic [xlen-1:0]    correction_pc_i,
    input  wire logic               btb_update_valid_i,
    input  wire btb_update_t        btb_update_i
);

    // fetch to ram
    logic               imem_ren;
    logic [imem_aw-1:0] imem_addr;
    logic [xlen-1:0]    imem_rdata;

    fetch_stage u_fetch_stage (
        .clk                (clk),
        .rst_n              (rst_n),
        .credit_return_i    (credit_return_i),
        .make_correction_i  (make_correction_i),
        .correction_pc_i    (correction_pc_i),
        .btb_update_valid_i (btb_update_valid_i),
        .btb_update_i       (btb_update_i),
        .imem_rdata_i       (imem_rdata),
        .imem_ren_o         (imem_ren),
        .imem_addr_o        (imem_addr),
        .pkt_valid_o        (pkt_valid_o),
        .pkt_o              (pkt_o)
    );

    inst_mem u_inst_mem (
        .clk     (clk),
        .ren_i   (imem_ren),
        .raddr_i (imem_addr),
        .we_i    (load_we_i),
        .waddr_i (load_addr_i),
        .wdata_i (load_data_i),
        .rdata_o (imem_rdata)
    );

endmodule

`default_nettype wire

// File: hw/inst_mem.sv
`timescale 1ns/100ps
`default_nettype none

module inst_mem import fetch_pkg::*; (
    input  wire logic               clk,
    // fetch read port
    input  wire logic               ren_i,
    input  wire logic [imem_aw-1:0] raddr_i,
    // program load port
    input  wire logic               we_i,
    input  wire logic [imem_aw-1:0] waddr_i,
    input  wire logic [xlen-1:0]    wdata_i,
    output logic      [xlen-1:0]    rdata_o
);

    // word storage
    logic [xlen-1:0] mem_q [imem_words];

    // load writes
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // registered read, data valid the cycle after ren_i
    // output holds between reads
    always_ff @(posedge clk) begin
        if (ren_i) begin
            rdata_o <= mem_q[raddr_i];
        end
    end

endmodule

`default_nettype wire

// File: hw/inst_realigner.sv
`timescale 1ns/100ps
`default_nettype none

module inst_realigner import fetch_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic [xlen-1:0]    pc_i,
    // memory side
    input  wire logic [xlen-1:0]    imem_rdata_i,
    output logic                    imem_ren_o,
    output logic      [imem_aw-1:0] imem_addr_o,
    // aligned instruction out
    output logic                    inst_ready_o,
    output logic                    compressed_o,
    output inst_word_u              inst_o
);

    // word holding the first half and the one after it
    logic [word_aw-1:0] wa;
    logic [word_aw-1:0] wa_next;

    // one-word line buffer
    logic               buf_valid_q;
    logic [word_aw-1:0] buf_addr_q;
    logic [xlen-1:0]    buf_word_q;
    // read presented to memory this cycle
    logic               req_valid_q;
    logic [word_aw-1:0] req_addr_q;
    // read whose data is on imem_rdata_i this cycle
    logic               rsp_valid_q;
    logic [word_aw-1:0] rsp_addr_q;

    logic               lo_from_buf, lo_from_rsp, lo_ok;
    logic               hi_from_buf, hi_from_rsp, hi_ok;
    logic [xlen-1:0]    lo_word, hi_word;
    logic [15:0]        first_half;
    logic               is_rvc, straddle;
    logic               buf_load;
    logic               req_lo, req_hi;
    logic               req_valid_d;
    logic [word_aw-1:0] req_addr_d;

    assign wa = pc_i[xlen-1:2];
    assign wa_next = wa + 1'b1;

    // a word is usable from the buffer or straight off the memory
    assign lo_from_buf = buf_valid_q && (buf_addr_q == wa);
    assign lo_from_rsp = rsp_valid_q && (rsp_addr_q == wa);
    assign hi_from_buf = buf_valid_q && (buf_addr_q == wa_next);
    assign hi_from_rsp = rsp_valid_q && (rsp_addr_q == wa_next);
    assign lo_ok = lo_from_buf || lo_from_rsp;
    assign hi_ok = hi_from_buf || hi_from_rsp;
    assign lo_word = lo_from_buf ? buf_word_q : imem_rdata_i;
    assign hi_word = hi_from_buf ? buf_word_q : imem_rdata_i;

    // halfword at the pc decides the length
    assign first_half = pc_i[1] ? lo_word[31:16] : lo_word[15:0];
    assign is_rvc = (first_half[1:0] != 2'b11);
    // 32-bit instruction whose upper half sits in the next word
    assign straddle = pc_i[1] && !is_rvc;

    assign inst_ready_o = lo_ok && (!straddle || hi_ok);
    assign compressed_o = inst_ready_o && is_rvc;

    always_comb begin
        if (!inst_ready_o) begin
            inst_o = nop_inst;
        end else if (is_rvc) begin
            // compressed goes in the low half, upper half zero
            inst_o = {16'h0000, first_half};
        end else if (straddle) begin
            inst_o = {hi_word[15:0], lo_word[31:16]};
        end else begin
            inst_o = lo_word;
        end
    end

    // keep returned data only if the current pc still wants it
    assign buf_load = lo_from_rsp || (hi_from_rsp && straddle);

    // fetch the first word, then the second one for a straddle
    // skip words already in flight
    assign req_lo = !lo_ok && !(req_valid_q && (req_addr_q == wa));
    assign req_hi = lo_ok && straddle && !hi_ok
                    && !(req_valid_q && (req_addr_q == wa_next));
    assign req_valid_d = req_lo || req_hi;
    assign req_addr_d = req_lo ? wa : wa_next;

    assign imem_ren_o = req_valid_q;
    assign imem_addr_o = req_addr_q[imem_aw-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            buf_valid_q <= 1'b0;
            req_valid_q <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            if (buf_load) begin
                buf_valid_q <= 1'b1;
            end
            req_valid_q <= req_valid_d;
            // memory answers one cycle after the request
            rsp_valid_q <= req_valid_q;
        end
    end

    // addresses and data
    always_ff @(posedge clk) begin
        if (buf_load) begin
            buf_addr_q <= rsp_addr_q;
            buf_word_q <= imem_rdata_i;
        end
        if (req_valid_d) begin
            req_addr_q <= req_addr_d;
        end
        rsp_addr_q <= req_addr_q;
    end

endmodule

`default_nettype wire

// File: tests/fetch_tb.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_tb import fetch_pkg::*; ();

    // expected packets of the sequential, back-pressure, correction, prediction and eviction phases
    localparam int unsigned total_pkts = 60 + 60 + 30 + 60 + 25;
    localparam int unsigned img_halves = imem_words * 2;
    localparam int unsigned img_aw = imem_aw + 1;
    localparam logic [31:0] seed = 32'hb3ae_f740;
    // instruction ordinals of the control transfers in the program
    localparam int unsigned jal_ord = 30;
    localparam int unsigned beq_ord = 50;
    localparam int unsigned bne_ord = 70;
    localparam int unsigned cj_ord = 90;

    logic clk, rst_n, load_done;

    logic               load_we;
    logic [imem_aw-1:0] load_addr;
    logic [xlen-1:0]    load_data;
    logic               credit_return;
    logic               make_correction;
    logic [xlen-1:0]    correction_pc;
    logic               btb_update_valid;
    btb_update_t        btb_update;
    logic               update_is_jump;
    logic               pkt_valid;
    fetch_pkt_t         pkt;

    // program image in halfwords and the start of every instruction
    logic [15:0]     img_h [img_halves];
    logic [xlen-1:0] starts [$];

    // reference walk
    logic [xlen-1:0] exp_pc, exp_next, exp_inst;
    logic            exp_comp;
    // trained entries kept direct mapped like the btb
    logic            ref_valid [btb_entries];
    logic [xlen-1:0] ref_pc [btb_entries];
    logic            ref_taken [btb_entries];
    logic            ref_jump [btb_entries];
    logic [xlen-1:0] ref_target [btb_entries];

    // decode side
    int unsigned dec_count = 0;
    int unsigned hold_cnt = 0;
    int unsigned max_delay = 3;
    int unsigned rx_count = 0;
    int unsigned cycle_cnt = 0;
    logic [31:0] lcg_state = seed;
    logic        rst_seen_q = 1'b0;
    string       test_name = "reset";

    tb_clock_gen u_clock_gen (
        .load_done_i (load_done),
        .clk         (clk),
        .rst_n       (rst_n)
    );

    fetch_top u_dut (
        .clk                (clk),
        .rst_n              (rst_n),
        .load_we_i          (load_we),
        .load_addr_i        (load_addr),
        .load_data_i        (load_data),
        .credit_return_i    (credit_return),
        .pkt_valid_o        (pkt_valid),
        .pkt_o              (pkt),
        .make_correction_i  (make_correction),
        .correction_pc_i    (correction_pc),
        .btb_update_valid_i (btb_update_valid),
        .btb_update_i       (btb_update)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string field, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_on_error($sformatf("error: %s %s expected %h actual %h",
                                test_name, field, expected, actual));
    endtask

    // length, contents and next pc at the expected pc
    always_comb begin : ref_decode
        logic [img_aw-1:0]    hidx;
        logic [btb_idx_w-1:0] bidx;
        logic                 redirect;
        hidx = exp_pc[img_aw:1];
        bidx = exp_pc[btb_idx_w:1];
        exp_comp = (img_h[hidx][1:0] != 2'b11);
        if (exp_comp) begin
            exp_inst = {16'h0000, img_h[hidx]};
        end else begin
            exp_inst = {img_h[hidx + 1'b1], img_h[hidx]};
        end
        redirect = ref_valid[bidx] && (ref_pc[bidx] == exp_pc)
                   && (ref_jump[bidx] || ref_taken[bidx]);
        exp_next = redirect ? ref_target[bidx] : exp_pc + (exp_comp ? 32'd2 : 32'd4);
    end

    // follow the stream with corrections taking priority
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        rst_seen_q <= rst_n;
        if (!rst_n) begin
            exp_pc <= '0;
            for (int i = 0; i < btb_entries; i++) begin
                ref_valid[i] <= 1'b0;
            end
        end else begin
            if (make_correction) begin
                exp_pc <= correction_pc;
            end else if (pkt_valid) begin
                exp_pc <= exp_next;
            end
            if (pkt_valid) begin
                rx_count <= rx_count + 1;
            end
            if (btb_update_valid) begin
                ref_valid[btb_update.pc[btb_idx_w:1]] <= 1'b1;
                ref_pc[btb_update.pc[btb_idx_w:1]] <= btb_update.pc;
                ref_taken[btb_update.pc[btb_idx_w:1]] <= btb_update.taken;
                ref_jump[btb_update.pc[btb_idx_w:1]] <= update_is_jump;
                ref_target[btb_update.pc[btb_idx_w:1]] <= btb_update.target;
            end
        end
    end

    // decode queue whose head leaves after a random hold and returns its credit
    always @(posedge clk) begin : decode_model
        int unsigned next_count;
        next_count = dec_count + (pkt_valid ? 1 : 0);
        if (!rst_n) begin
            dec_count <= 0;
            hold_cnt <= 0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= 1'b0;
            if (dec_count != 0) begin
                if (hold_cnt == 0) begin
                    credit_return <= 1'b1;
                    next_count = next_count - 1;
                    lcg_state = lcg_next(lcg_state);
                    hold_cnt <= lcg_state[31:16] % (max_delay + 1);
                end else begin
                    hold_cnt <= hold_cnt - 1;
                end
            end
            dec_count <= next_count;
        end
    end

    // quiet through reset and the cycle after
    assert property (@(posedge clk) (cycle_cnt == 0) || (rst_n && rst_seen_q) || !pkt_valid)
        else report_mismatch("pkt_valid", 32'd0, 32'(pkt_valid));
    assert property (@(posedge clk) disable iff (!rst_n) pkt_valid |-> (pkt.pc == exp_pc))
        else report_mismatch("pc", exp_pc, pkt.pc);
    assert property (@(posedge clk) disable iff (!rst_n) pkt_valid |-> (pkt.inst == exp_inst))
        else report_mismatch("inst", exp_inst, pkt.inst);
    assert property (@(posedge clk) disable iff (!rst_n)
                     pkt_valid |-> (pkt.compressed == exp_comp))
        else report_mismatch("compressed", 32'(exp_comp), 32'(pkt.compressed));
    assert property (@(posedge clk) disable iff (!rst_n)
                     (pkt_valid && pkt.compressed) |-> (pkt.inst.rvc.pad == 16'h0000))
        else report_mismatch("upper half", 32'd0, 32'(pkt.inst.rvc.pad));
    assert property (@(posedge clk) disable iff (!rst_n)
                     pkt_valid |-> (pkt.pred_dest == exp_next))
        else report_mismatch("pred_dest", exp_next, pkt.pred_dest);
    // never more packets held than credits exist
    assert property (@(posedge clk) disable iff (!rst_n) dec_count <= fetch_credits)
        else report_mismatch("outstanding", fetch_credits, dec_count);

    // random mix of 16 and 32 bit, jal, beq, bne and c.j at fixed ordinals
    task automatic build_program();
        int unsigned cursor;
        int unsigned ord;
        logic [31:0] r;
        logic [31:0] word;
        logic        len4;
        cursor = 0;
        ord = 0;
        while (cursor < img_halves * 2) begin
            lcg_state = lcg_next(lcg_state);
            r = lcg_state ^ cursor;
            starts.push_back(cursor);
            len4 = 1'b1;
            if (ord == jal_ord) begin
                word = {r[31:12], 5'd1, opcode_jal};
            end else if (ord == beq_ord) begin
                word = {r[31:15], 3'b000, r[11:7], opcode_branch};
            end else if (ord == bne_ord) begin
                word = {r[31:15], 3'b001, r[11:7], opcode_branch};
            end else if (ord == cj_ord) begin
                word = {16'h0000, 3'b101, r[12:2], 2'b01};
                len4 = 1'b0;
            end else if (r[20] && (cursor < img_halves * 2 - 2)) begin
                word = {r[31:2], 2'b11};
            end else begin
                word = {16'h0000, r[15:2], (r[1:0] == 2'b11) ? 2'b10 : r[1:0]};
                len4 = 1'b0;
            end
            img_h[cursor / 2] = word[15:0];
            if (len4) begin
                img_h[cursor / 2 + 1] = word[31:16];
            end
            cursor += len4 ? 4 : 2;
            ord++;
        end
    endtask

    task automatic load_program();
        for (int w = 0; w < imem_words; w++) begin
            @(posedge clk);
            load_we <= 1'b1;
            load_addr <= imem_aw'(w);
            load_data <= {img_h[2 * w + 1], img_h[2 * w]};
        end
        @(posedge clk);
        load_we <= 1'b0;
        load_done <= 1'b1;
    endtask

    task automatic wait_packets(input int unsigned n);
        int unsigned target;
        target = rx_count + n;
        while (rx_count < target) begin
            @(posedge clk);
        end
    endtask

    // one correction cycle that may also write a btb entry at the same edge
    task automatic correct_to(input logic [31:0] restart_pc, input logic train,
                              input logic [31:0] pc, input logic taken, input logic jump,
                              input logic [31:0] target);
        @(posedge clk);
        make_correction <= 1'b1;
        correction_pc <= restart_pc;
        btb_update_valid <= train;
        btb_update.pc <= pc;
        btb_update.taken <= taken;
        btb_update.target <= target;
        update_is_jump <= jump;
        @(posedge clk);
        make_correction <= 1'b0;
        btb_update_valid <= 1'b0;
    endtask

    initial begin
        #(total_pkts * 20 * 10);
        stop_on_error("error: watchdog expired before all packets reached decode");
    end

    initial begin
        load_done = 1'b0;
        load_we = 1'b0;
        load_addr = '0;
        load_data = '0;
        credit_return = 1'b0;
        make_correction = 1'b0;
        correction_pc = '0;
        btb_update_valid = 1'b0;
        btb_update = '0;
        update_is_jump = 1'b0;
        build_program();
        load_program();
        while (!rst_n) begin
            @(posedge clk);
        end
        test_name = "sequential";
        wait_packets(60);
        // long holds fill the decode queue
        test_name = "backpressure";
        max_delay <= 15;
        wait_packets(60);
        test_name = "correction";
        max_delay <= 3;
        correct_to(starts[121], 1'b0, '0, 1'b0, 1'b0, '0);
        wait_packets(30);
        test_name = "prediction";
        correct_to(starts[jal_ord - 3], 1'b1, starts[jal_ord], 1'b1, 1'b1, starts[jal_ord + 10]);
        correct_to(starts[jal_ord - 3], 1'b1, starts[beq_ord], 1'b1, 1'b0, starts[beq_ord + 10]);
        correct_to(starts[jal_ord - 3], 1'b1, starts[bne_ord], 1'b0, 1'b0, starts[bne_ord + 10]);
        correct_to(starts[jal_ord - 3], 1'b1, starts[cj_ord], 1'b1, 1'b1, starts[cj_ord + 10]);
        wait_packets(60);
        // same index as the beq with an unreachable tag
        test_name = "eviction";
        correct_to(starts[beq_ord - 3], 1'b1, starts[beq_ord] | 32'h8000_0000, 1'b1, 1'b0,
                   starts[0]);
        wait_packets(25);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int unsigned period_ns = 10,
    parameter int unsigned reset_cycles = 5
) (
    // reset stays low until the program is in memory
    input  wire logic load_done_i,
    output logic      clk,
    output logic      rst_n
);

    int unsigned cycles_q = 0;

    initial clk = 1'b0;
    always #(period_ns / 2) clk = ~clk;

    // count edges after the load, then release
    always @(posedge clk) begin
        if (!load_done_i) begin
            cycles_q <= 0;
        end else if (cycles_q < reset_cycles) begin
            cycles_q <= cycles_q + 1;
        end
    end

    assign rst_n = (cycles_q == reset_cycles);

endmodule

`default_nettype wire
